/* font.hex */
// one 16-bit glyph row per line, char 0 row 0 first, bit 15 is the leftmost pixel
3C00
6618
6E24
7642
667E
6642
3C42
0000
1800
3899
1842
1824
1818
1824
7E42
0099
3C0F
661E
0C3C
1878
30F0
60E1
7EC3
0087
3CFF
6681
0CBD
06A5
66A5
66BD
3C81
00FF
0C01
1C02
3C04
6C08
FE10
0C20
0C40
0080
7EAA
6055
7CAA
0655
06AA
6655
3CAA
0055
FFFF
8001
8001
8001
8001
8001
8001
FFFF
AA55
55AA
AA55
55AA
AA55
55AA
AA55
55AA

/* list.f */
osd_pkg.sv
osd_delay_line.sv
osd_glyph_fetch.sv
osd_lane_blend.sv
osd_output_mux.sv
osd_overlay_top.sv
tb_osd_overlay.sv

/* Bender.yml */
package:
  name: osd_overlay

sources:
  - files:
      - osd_pkg.sv
      - osd_delay_line.sv
      - osd_glyph_fetch.sv
      - osd_lane_blend.sv
      - osd_output_mux.sv
      - osd_overlay_top.sv
  - target: test
    files:
      - tb_osd_overlay.sv

/* tb_osd_overlay.sv */
// drives osd_overlay_top with inputs changing on the falling edge
// expected words wait in a queue and are checked 5 clocks after they go in
// the reference model reads the same font.hex as the DUT
`timescale 1ns/1ps

module tb_osd_overlay;

	import osd_pkg::*;

	localparam int latency = 5;
	localparam int n_tests = 6;

	logic               clk;
	logic               i_rst_n;
	logic               i_de;
	logic               i_hs;
	logic               i_vs;
	bus_t               i_data;
	logic [instr_w-1:0] i_instr;
	logic               o_de;
	logic               o_hs;
	logic               o_vs;
	bus_t               o_data;

	logic [glyph_w-1:0] font_ref [font_depth];
	integer             seed;

	// one entry per word in flight with the head on the outputs
	bus_t  q_data [$];
	sync_t q_sync [$];
	int    q_test [$];
	bit    q_chk  [$];
	int    pending;   // checked entries still queued

	bus_t  exp_data;
	sync_t exp_sync;
	int    exp_test;
	bit    chk_en;
	int    cur_test;
	int    errs [n_tests];

	osd_overlay_top i_osd_overlay_top (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_de    (i_de),
		.i_hs    (i_hs),
		.i_vs    (i_vs),
		.i_data  (i_data),
		.i_instr (i_instr),
		.o_de    (o_de),
		.o_hs    (o_hs),
		.o_vs    (o_vs),
		.o_data  (o_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////
	// checks
	a_data: assert property (@(posedge clk) chk_en |-> (o_data == exp_data))
		else report_mismatch(exp_test, "o_data", exp_data, $sampled(o_data));

	a_sync: assert property (@(posedge clk) chk_en |-> ({o_de, o_hs, o_vs} == exp_sync))
		else report_mismatch(exp_test, "syncs", exp_sync, $sampled({o_de, o_hs, o_vs}));

	function automatic string test_name(int id);
		case (id)
			0: return "reset";
			1: return "bypass";
			2: return "glyph_colours";
			3: return "backgrounds";
			4: return "offsets";
			5: return "mixed_stream";
			default: return "unknown";
		endcase
	endfunction

	task automatic report_mismatch(input int test, input string what, input bus_t expv,
		input bus_t actv);
		errs[test]++;
		$display("Mismatch test %s %s expected %0h actual %0h", test_name(test), what,
			expv, actv);
	endtask

	//////////////////////////////
	// reference model
	function automatic bus_t model_bus(bus_t pix, logic [instr_w-1:0] instr);
		logic [glyph_w-1:0] shifted;
		logic [7:0]         win;
		logic [2:0]         color;
		logic [9:0]         comp [3];
		bus_t               res;
		if (!instr[12]) begin
			return pix;   // enable low leaves the word untouched
		end
		// char in 11:9, row in 8:6, hoff in 5:3
		shifted = font_ref[instr[11:9] * 8 + instr[8:6]] << instr[5:3];
		win     = shifted[15:8];
		color   = instr[2:0];
		res     = '0;
		for (int l = 0; l < 8; l++) begin
			for (int c = 0; c < 3; c++) begin
				comp[c] = pix[239 - 30 * l - 10 * c -: 10];
			end
			if (win[7 - l]) begin
				comp[0] = 10'h3FF;
				comp[1] = color[0] ? 10'h000 : 10'h3FF;
				comp[2] = color[0] ? 10'h000 : 10'h3FF;
			end else if (color[2]) begin
				comp[0] = 10'h000;
				comp[1] = 10'h000;
				comp[2] = 10'h300;
			end else if (color[1]) begin
				comp[0] = 10'h00F;
				comp[1] = 10'h00F;
				comp[2] = 10'h00F;
			end else begin
				for (int c = 0; c < 3; c++) begin
					comp[c] = (comp[c] >> 2) + 10'h100;
				end
			end
			res[239 - 30 * l -: 30] = {comp[0], comp[1], comp[2]};
		end
		return res;
	endfunction

	function automatic bus_t random_bus();
		bus_t r;
		r = '0;
		for (int w = 0; w < 8; w++) begin
			r = {r[bus_w-33:0], $random(seed)};
		end
		return r;
	endfunction

	function automatic logic [instr_w-1:0] make_instr(logic en, logic [2:0] ch,
		logic [2:0] row, logic [2:0] hoff, logic [2:0] color);
		return {en, ch, row, hoff, color};
	endfunction

	//////////////////////////////
	// stimulus
	task automatic push_expected(input bit chk, input bus_t data, input sync_t sync);
		q_data.push_back(data);
		q_sync.push_back(sync);
		q_test.push_back(cur_test);
		q_chk.push_back(chk);
		if (chk) begin
			pending++;
		end
	endtask

	// present the oldest expectation and drive the next word
	task automatic step(input bit chk, input bus_t data, input logic [instr_w-1:0] instr,
		input sync_t sync);
		@(negedge clk);
		exp_data = q_data.pop_front();
		exp_sync = q_sync.pop_front();
		exp_test = q_test.pop_front();
		chk_en   = q_chk.pop_front();
		if (chk_en) begin
			pending--;
		end
		i_data  = data;
		i_instr = instr;
		{i_de, i_hs, i_vs} = sync;
		push_expected(chk, model_bus(data, instr), sync);
	endtask

	// idle words until every checked word has come out
	task automatic drain();
		int guard;
		guard = 0;
		while (pending > 0 && guard < 4 * latency) begin
			step(1'b0, '0, '0, '0);
			guard++;
		end
		if (pending > 0) begin
			$display("timeout: %0d words never reached the outputs in test %s", pending,
				test_name(cur_test));
			$display("Verification failed");
			$finish;
		end else begin
			step(1'b0, '0, '0, '0);   // last check lands on this edge
			$display("test %s done, %0d errors", test_name(cur_test), errs[cur_test]);
		end
	endtask

	initial begin
		logic [31:0] rnd;
		bus_t        pix;
		int          total;
		seed     = 13096;
		i_rst_n  = 1'b0;
		i_de     = 1'b0;
		i_hs     = 1'b0;
		i_vs     = 1'b0;
		i_data   = '0;
		i_instr  = '0;
		chk_en   = 1'b0;
		exp_data = '0;
		exp_sync = '0;
		exp_test = 0;
		pending  = 0;
		cur_test = 0;
		total    = 0;
		for (int t = 0; t < n_tests; t++) begin
			errs[t] = 0;
		end
		$readmemh("font.hex", font_ref);

		// 8 clocks of reset with busy inputs, outputs zero from the first edge
		repeat (7) begin
			@(negedge clk);
			chk_en = 1'b1;
			rnd = $random(seed);
			i_data  = random_bus();
			i_instr = make_instr(1'b1, rnd[2:0], rnd[5:3], rnd[8:6], rnd[11:9]);
			{i_de, i_hs, i_vs} = rnd[14:12];
		end
		@(negedge clk);
		i_rst_n = 1'b1;
		i_data  = '0;
		i_instr = '0;
		{i_de, i_hs, i_vs} = 3'b000;
		repeat (latency) begin
			push_expected(1'b1, '0, '0);   // cleared pipeline
		end
		drain();

		cur_test = 1;
		for (int k = 0; k < 32; k++) begin
			rnd = $random(seed);
			step(1'b1, random_bus(), make_instr(1'b0, rnd[2:0], rnd[5:3], rnd[8:6], rnd[11:9]),
				rnd[14:12]);
		end
		drain();

		cur_test = 2;
		for (int ch_i = 0; ch_i < 8; ch_i++) begin
			for (int row_i = 0; row_i < 8; row_i++) begin
				for (int hl = 0; hl < 2; hl++) begin
					rnd = $random(seed);
					step(1'b1, random_bus(), make_instr(1'b1, ch_i[2:0], row_i[2:0], 3'd0,
						{2'b00, hl[0]}), rnd[2:0]);
				end
			end
		end
		drain();

		cur_test = 3;
		for (int k = 0; k < 64; k++) begin
			rnd = $random(seed);
			pix = (k[5:3] == 3'd2) ? '1 : random_bus();   // all-ones components too
			step(1'b1, pix, make_instr(1'b1, rnd[2:0], rnd[5:3], 3'd0, k[2:0]), rnd[8:6]);
		end
		drain();

		cur_test = 4;
		for (int k = 0; k < 64; k++) begin
			rnd = $random(seed);
			step(1'b1, random_bus(), make_instr(1'b1, rnd[2:0], rnd[5:3], rnd[8:6], rnd[11:9]),
				rnd[14:12]);
		end
		drain();

		cur_test = 5;
		for (int k = 0; k < 64; k++) begin
			rnd = $random(seed);
			step(1'b1, random_bus(), make_instr(k[0], rnd[2:0], rnd[5:3], rnd[8:6], rnd[11:9]),
				rnd[14:12]);
		end
		drain();

		for (int t = 0; t < n_tests; t++) begin
			total += errs[t];
		end
		$display("tests run %0d, errors %0d", n_tests, total);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* osd_overlay_top.sv */
// osd overlay on an 8 pixel per clock stream, 5 clock latency on every output
// one instruction word per clock, no back-pressure, i_de only travels with the syncs
// lane 0 is the top pixel of the bus and takes the top window bit
`timescale 1ns/1ps

module osd_overlay_top (
	input  logic                         clk,
	input  logic                         i_rst_n,
	input  logic                         i_de,
	input  logic                         i_hs,
	input  logic                         i_vs,
	input  osd_pkg::bus_t                i_data,
	input  logic [osd_pkg::instr_w-1:0]  i_instr,
	output logic                         o_de,
	output logic                         o_hs,
	output logic                         o_vs,
	output osd_pkg::bus_t                o_data
);

	import osd_pkg::*;

	logic [lanes-1:0]   window;
	logic               glyph_en;
	logic [color_w-1:0] glyph_color;
	bus_t               pix_d3;      // original pixels at the window stage
	bus_t               blended;
	sync_t              sync_out;

	//////////////////////////////
	// glyph side, 3 clocks
	osd_glyph_fetch i_glyph_fetch (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_instr  (i_instr),
		.o_window (window),
		.o_en     (glyph_en),
		.o_color  (glyph_color)
	);

	// pixels to the same point
	osd_delay_line #(
		.T_payload (bus_t),
		.depth     (3)
	) i_pixel_delay (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_data  (i_data),
		.o_data  (pix_d3)
	);

	//////////////////////////////
	// eight lanes, glyph msb to lane 0
	for (genvar lane_idx = 0; lane_idx < lanes; lane_idx++) begin : g_lane
		osd_lane_blend i_lane_blend (
			.clk         (clk),
			.i_glyph_bit (window[lanes-1-lane_idx]),
			.i_color     (glyph_color),
			.i_pixel     (pix_d3[bus_w-1-lane_idx*pixel_w -: pixel_w]),
			.o_pixel     (blended[bus_w-1-lane_idx*pixel_w -: pixel_w])
		);
	end

	osd_output_mux i_output_mux (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_en      (glyph_en),
		.i_bypass  (pix_d3),
		.i_blended (blended),
		.o_data    (o_data)
	);

	//////////////////////////////
	// syncs, same 5 clocks as o_data
	osd_delay_line #(
		.T_payload (sync_t),
		.depth     (5)
	) i_sync_delay (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_data  ({i_de, i_hs, i_vs}),
		.o_data  (sync_out)
	);

	assign {o_de, o_hs, o_vs} = sync_out;

endmodule

/* osd_output_mux.sv */
// picks blended or original bus, o_data registered, clears on reset
// bypass and enable arrive a clock before the blended bus
`timescale 1ns/1ps

module osd_output_mux (
	input  logic          clk,
	input  logic          i_rst_n,
	input  logic          i_en,
	input  osd_pkg::bus_t i_bypass,
	input  osd_pkg::bus_t i_blended,
	output osd_pkg::bus_t o_data
);

	import osd_pkg::*;

	logic en_q;     // aligned with lane outputs
	bus_t bypass_q;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			en_q <= 1'b0;
		end else begin
			en_q <= i_en;
		end
	end

	always_ff @(posedge clk) begin
		bypass_q <= i_bypass;
	end

	//////////////////////////////
	// output register
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_data <= '0;
		end else if (en_q) begin
			o_data <= i_blended;   // overlay
		end else begin
			o_data <= bypass_q;    // pass through untouched
		end
	end

endmodule

/* osd_lane_blend.sv */
// one pixel lane, registered, 1 clock
// priority: glyph bit, then select row, then dim, then quartered pixel
`timescale 1ns/1ps

module osd_lane_blend (
	input  logic                         clk,
	input  logic                         i_glyph_bit,
	input  logic [osd_pkg::color_w-1:0]  i_color,
	input  osd_pkg::pixel_t              i_pixel,
	output osd_pkg::pixel_t              o_pixel
);

	import osd_pkg::*;

	logic [comp_w-1:0] r_in, g_in, b_in;

	assign r_in = i_pixel[pixel_w-1 -: comp_w];
	assign g_in = i_pixel[pixel_w-1-comp_w -: comp_w];
	assign b_in = i_pixel[comp_w-1:0];

	always_ff @(posedge clk) begin
		if (i_glyph_bit) begin
			if (i_color[color_hl_bit]) begin
				o_pixel <= {hlight_r, hlight_g, hlight_b};
			end else begin
				o_pixel <= {front_r, front_g, front_b};
			end
		end else if (i_color[color_sel_bit]) begin
			o_pixel <= {sele_r, sele_g, sele_b};
		end else if (i_color[color_dim_bit]) begin
			o_pixel <= {back_dim, back_dim, back_dim};
		end else begin
			o_pixel <= {(r_in >> 2) + back_lift, (g_in >> 2) + back_lift, (b_in >> 2) + back_lift};
		end
	end

endmodule

/* osd_glyph_fetch.sv */
// instruction to glyph window in 3 clocks, one instruction per clock
// font rom contents come from font_file at elaboration
// only the enable is reset, colour and window follow it
`timescale 1ns/1ps

module osd_glyph_fetch (
	input  logic                         clk,
	input  logic                         i_rst_n,
	input  logic [osd_pkg::instr_w-1:0]  i_instr,
	output logic [osd_pkg::lanes-1:0]    o_window,
	output logic                         o_en,
	output logic [osd_pkg::color_w-1:0]  o_color
);

	import osd_pkg::*;

	logic                       instr_en;
	logic [char_w-1:0]          instr_char;
	logic [row_w-1:0]           instr_row;
	logic [hoff_w-1:0]          instr_hoff;
	logic [color_w-1:0]         instr_color;

	logic [glyph_w-1:0]         font_rom [font_depth];
	logic [char_w+row_w-1:0]    rom_addr;
	logic [glyph_w-1:0]         rom_word;
	logic [glyph_w-1:0]         shifted;
	logic [lanes-1:0]           window_q;

	logic                       en_d1, en_d2, en_d3;
	logic [color_w-1:0]         color_d1, color_d2, color_d3;
	logic [hoff_w-1:0]          hoff_d1, hoff_d2;

	// field decode
	assign instr_en    = i_instr[instr_en_bit];
	assign instr_char  = i_instr[instr_char_lsb +: char_w];
	assign instr_row   = i_instr[instr_row_lsb +: row_w];
	assign instr_hoff  = i_instr[instr_hoff_lsb +: hoff_w];
	assign instr_color = i_instr[instr_color_lsb +: color_w];

	initial begin
		$readmemh(font_file, font_rom);
	end

	//////////////////////////////
	// address, rom read, window
	assign shifted = rom_word << hoff_d2; // offset slides the glyph left

	always_ff @(posedge clk) begin
		rom_addr <= {instr_char, instr_row}; // char * 8 + row
		rom_word <= font_rom[rom_addr];
		window_q <= shifted[glyph_w-1 -: lanes];
	end

	//////////////////////////////
	// sideband alongside the data
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			en_d1 <= 1'b0;
			en_d2 <= 1'b0;
			en_d3 <= 1'b0;
		end else begin
			en_d1 <= instr_en;
			en_d2 <= en_d1;
			en_d3 <= en_d2;
		end
	end

	always_ff @(posedge clk) begin
		color_d1 <= instr_color;
		color_d2 <= color_d1;
		color_d3 <= color_d2;
		hoff_d1  <= instr_hoff;
		hoff_d2  <= hoff_d1;    // lines up with rom_word
	end

	assign o_window = window_q;
	assign o_en     = en_d3;
	assign o_color  = color_d3;

endmodule

/* osd_delay_line.sv */
// fixed latency of exactly depth clocks, depth must be at least 1
// every stage clears on reset, payload type must be a packed type
`timescale 1ns/1ps

module osd_delay_line #(
	parameter type         T_payload = logic,
	parameter int unsigned depth     = 1
) (
	input  logic     clk,
	input  logic     i_rst_n,
	input  T_payload i_data,
	output T_payload o_data
);

	T_payload stage [depth]; // stage 0 nearest the input

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < depth; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= i_data;
			for (int i = 1; i < depth; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign o_data = stage[depth-1];

endmodule

/* osd_pkg.sv */
// shared widths, colours and instruction layout for the osd overlay
// eight 30-bit pixels per clock, lane 0 in the top bits, r g b from msb
// instruction from msb: enable, char, row, hoff, color
package osd_pkg;

	//////////////////////////////
	// pixel bus
	localparam int comp_w  = 10;
	localparam int lanes   = 8;
	localparam int pixel_w = 3 * comp_w;
	localparam int bus_w   = lanes * pixel_w;

	//////////////////////////////
	// instruction fields
	localparam int char_w  = 3;
	localparam int row_w   = 3;
	localparam int hoff_w  = 3;
	localparam int color_w = 3;
	localparam int instr_w = 1 + char_w + row_w + hoff_w + color_w;

	localparam int instr_color_lsb = 0;
	localparam int instr_hoff_lsb  = instr_color_lsb + color_w;
	localparam int instr_row_lsb   = instr_hoff_lsb + hoff_w;
	localparam int instr_char_lsb  = instr_row_lsb + row_w;
	localparam int instr_en_bit    = instr_char_lsb + char_w; // top bit

	// bits inside the colour field
	localparam int color_hl_bit  = 0;
	localparam int color_dim_bit = 1;
	localparam int color_sel_bit = 2;

	//////////////////////////////
	// font rom
	localparam int    glyph_w    = 16;
	localparam int    font_depth = 64;  // 8 chars x 8 rows
	localparam string font_file  = "font.hex";

	//////////////////////////////
	// colours
	localparam logic [comp_w-1:0] front_r = 10'h3FF;
	localparam logic [comp_w-1:0] front_g = 10'h3FF;
	localparam logic [comp_w-1:0] front_b = 10'h3FF;

	localparam logic [comp_w-1:0] hlight_r = 10'h3FF;
	localparam logic [comp_w-1:0] hlight_g = 10'h000;
	localparam logic [comp_w-1:0] hlight_b = 10'h000;

	localparam logic [comp_w-1:0] sele_r = 10'h000;
	localparam logic [comp_w-1:0] sele_g = 10'h000;
	localparam logic [comp_w-1:0] sele_b = 10'h300;

	localparam logic [comp_w-1:0] back_lift = 10'h100; // grey added to quartered pixel
	localparam logic [comp_w-1:0] back_dim  = 10'h00F;

	//////////////////////////////
	// types
	typedef logic [pixel_w-1:0] pixel_t;
	typedef logic [bus_w-1:0]   bus_t;
	typedef logic [2:0]         sync_t; // {de, hs, vs}

endpackage
